//--- vlog.f
hw/lsu_pkg.sv
hw/cla_adder.sv
hw/ld_st_queue.sv
hw/address_unit.sv
hw/phys_reg_file.sv
hw/lsu_top.sv
dv/dmem_model.sv
dv/tb_lsu.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = tb_lsu
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "tests failed" $(LOG); then exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu;

    import lsu_pkg::*;

    localparam int N_ROWS      = 16;
    localparam int WATCHDOG_NS = ((N_ROWS + 3) * 40 + 200) * 20;

    logic              clk;
    logic              reset;
    logic              dispatch_valid;
    instr_t            instr;
    logic [PREG_W-1:0] ps1;
    logic [PREG_W-1:0] ps2;
    logic [PREG_W-1:0] pd;
    logic [ROB_W-1:0]  rob_index;
    logic              alu_we;
    logic [PREG_W-1:0] alu_pd;
    logic [31:0]       alu_value;
    logic [ROB_W-1:0]  rob_head;
    logic              flush;
    logic [31:0]       dmem_addr;
    logic [3:0]        dmem_rmask;
    logic [3:0]        dmem_wmask;
    logic [31:0]       dmem_wdata;
    logic              dmem_resp;
    logic [31:0]       dmem_rdata;
    logic              lsq_full;
    logic              wb_valid;
    logic              wb_we;
    logic [PREG_W-1:0] wb_pd;
    logic [31:0]       wb_value;
    logic [ROB_W-1:0]  wb_rob_index;

    // stimulus table
    instr_t            t_instr [N_ROWS];
    logic              t_store [N_ROWS];
    logic [31:0]       t_imm   [N_ROWS];
    logic [PREG_W-1:0] t_ps1   [N_ROWS];
    logic [PREG_W-1:0] t_ps2   [N_ROWS];
    logic [PREG_W-1:0] t_pd    [N_ROWS];
    logic [ROB_W-1:0]  t_rob   [N_ROWS];
    logic [31:0]       t_base  [N_ROWS];
    logic [31:0]       t_data  [N_ROWS];
    logic              t_wait  [N_ROWS];
    int                n_rows;

    logic [7:0] ref_mem [1024];
    int         errors;

    lsu_top dut_i (
        .clk(clk), .reset(reset), .dispatch_valid(dispatch_valid), .instr(instr),
        .ps1(ps1), .ps2(ps2), .pd(pd), .rob_index(rob_index),
        .alu_we(alu_we), .alu_pd(alu_pd), .alu_value(alu_value),
        .rob_head(rob_head), .flush(flush),
        .dmem_addr(dmem_addr), .dmem_rmask(dmem_rmask), .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata), .dmem_resp(dmem_resp), .dmem_rdata(dmem_rdata),
        .lsq_full(lsq_full), .wb_valid(wb_valid), .wb_we(wb_we), .wb_pd(wb_pd),
        .wb_value(wb_value), .wb_rob_index(wb_rob_index)
    );

    dmem_model mem_i (
        .clk(clk), .reset(reset), .addr(dmem_addr), .rmask(dmem_rmask),
        .wmask(dmem_wmask), .wdata(dmem_wdata), .resp(dmem_resp), .rdata(dmem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got, exp);
        if (got !== exp)
        begin
            $display("mismatch %s got %08h expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mask(input string name, input logic [3:0] got, exp);
        if (got !== exp)
        begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_preg(input string name, input logic [PREG_W-1:0] got, exp);
        if (got !== exp)
        begin
            $display("mismatch %s got %02h expected %02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rob(input string name, input logic [ROB_W-1:0] got, exp);
        if (got !== exp)
        begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp)
        begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input logic st, input logic [2:0] f3, input logic [11:0] imm,
                           input logic [31:0] base, input logic [31:0] data,
                           input logic wait_rob);
        instr_t w;
        w = '0;
        if (st)
        begin
            w.s_type.imm_11_5 = imm[11:5];
            w.s_type.imm_4_0  = imm[4:0];
            w.s_type.funct3   = f3;
            w.s_type.opcode   = op_store;
        end
        else
        begin
            w.i_type.imm_11_0 = imm;
            w.i_type.funct3   = f3;
            w.i_type.opcode   = op_load;
        end
        t_instr[n_rows] = w;
        t_store[n_rows] = st;
        t_imm[n_rows]   = {{20{imm[11]}}, imm};
        t_ps1[n_rows]   = 6'd5;
        t_ps2[n_rows]   = st ? 6'd6 : 6'd0;
        t_pd[n_rows]    = st ? 6'd0 : PREG_W'(10 + n_rows);
        t_rob[n_rows]   = ROB_W'(n_rows);
        t_base[n_rows]  = base;
        t_data[n_rows]  = data;
        t_wait[n_rows]  = wait_rob;
        n_rows++;
    endtask

    task automatic write_preg(input logic [PREG_W-1:0] r, input logic [31:0] v);
        @(posedge clk);
        #2;
        alu_we    = 1'b1;
        alu_pd    = r;
        alu_value = v;
        @(posedge clk);
        #2;
        alu_we = 1'b0;
    endtask

    task automatic dispatch(input instr_t w, input logic [PREG_W-1:0] s1, s2, d,
                            input logic [ROB_W-1:0] rob);
        @(posedge clk);
        #2;
        dispatch_valid = 1'b1;
        instr          = w;
        ps1            = s1;
        ps2            = s2;
        pd             = d;
        rob_index      = rob;
        @(posedge clk);
        #2;
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_request(output logic ok);
        ok = 1'b0;
        for (int k = 0; k < 100 && !ok; k++)
        begin
            @(negedge clk);
            ok = ((dmem_rmask | dmem_wmask) != 4'b0000);
        end
        if (!ok)
        begin
            $display("no memory request appeared");
            errors++;
        end
    endtask

    task automatic wait_wb(output logic ok);
        ok = 1'b0;
        for (int k = 0; k < 100 && !ok; k++)
        begin
            @(negedge clk);
            ok = wb_valid;
        end
        if (!ok)
        begin
            $display("no result came back from memory");
            errors++;
        end
    endtask

    task automatic store_ref(input logic [31:0] a, input logic [3:0] m, input logic [31:0] d);
        for (int b = 0; b < 4; b++)
            if (m[b])
                ref_mem[int'(a[9:0]) + b] = d[8*b +: 8];
    endtask

    task automatic apply_row(input int i);
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] exp_val;
        logic [31:0] exp_wdata;
        logic [3:0]  exp_mask;
        logic [2:0]  f3;
        logic        ok;
        addr      = t_base[i] + t_imm[i];
        f3        = t_store[i] ? t_instr[i].s_type.funct3 : t_instr[i].i_type.funct3;
        exp_wdata = '0;
        case (f3[1:0])
            2'b00:
            begin
                exp_mask = 4'b0001 << addr[1:0];
                exp_wdata[8*addr[1:0] +: 8] = t_data[i][7:0];
            end
            2'b01:
            begin
                exp_mask = addr[1] ? 4'b1100 : 4'b0011;
                exp_wdata[16*addr[1] +: 16] = t_data[i][15:0];
            end
            default:
            begin
                exp_mask  = 4'b1111;
                exp_wdata = t_data[i];
            end
        endcase
        write_preg(t_ps1[i], t_base[i]);
        if (t_store[i])
            write_preg(t_ps2[i], t_data[i]);
        rob_head = t_wait[i] ? t_rob[i] + 1'b1 : t_rob[i];
        dispatch(t_instr[i], t_ps1[i], t_ps2[i], t_pd[i], t_rob[i]);
        if (t_wait[i])
        begin
            repeat (8)
            begin
                @(negedge clk);
                if ((dmem_rmask | dmem_wmask) != 4'b0000)
                begin
                    $display("store issued before its rob index reached the head");
                    errors++;
                end
            end
            @(posedge clk);
            #2;
            rob_head = t_rob[i];
        end
        wait_request(ok);
        if (ok)
        begin
            check_value("dmem_addr", dmem_addr, {addr[31:2], 2'b00});
            check_mask("dmem_wmask", dmem_wmask, t_store[i] ? exp_mask : 4'b0000);
            check_mask("dmem_rmask", dmem_rmask, t_store[i] ? 4'b0000 : exp_mask);
            if (t_store[i])
            begin
                check_value("dmem_wdata", dmem_wdata, exp_wdata);
                store_ref({addr[31:2], 2'b00}, exp_mask, exp_wdata);
            end
        end
        for (int b = 0; b < 4; b++)
            word[8*b +: 8] = ref_mem[{addr[9:2], 2'b00} + b];
        case (f3)
            f3_lb:   exp_val = {{24{word[8*addr[1:0] + 7]}}, word[8*addr[1:0] +: 8]};
            f3_lbu:  exp_val = {24'h0, word[8*addr[1:0] +: 8]};
            f3_lh:   exp_val = {{16{word[16*addr[1] + 15]}}, word[16*addr[1] +: 16]};
            f3_lhu:  exp_val = {16'h0, word[16*addr[1] +: 16]};
            default: exp_val = word;
        endcase
        wait_wb(ok);
        if (ok)
        begin
            check_bit("wb_we", wb_we, !t_store[i]);
            check_rob("wb_rob_index", wb_rob_index, t_rob[i]);
            if (!t_store[i])
            begin
                check_preg("wb_pd", wb_pd, t_pd[i]);
                check_value("wb_value", wb_value, exp_val);
            end
        end
    endtask

    initial
    begin
        logic ok;
        void'($urandom(13));
        errors         = 0;
        n_rows         = 0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        instr          = '0;
        ps1            = '0;
        ps2            = '0;
        pd             = '0;
        rob_index      = '0;
        alu_we         = 1'b0;
        alu_pd         = '0;
        alu_value      = '0;
        rob_head       = '0;
        flush          = 1'b0;
        for (int a = 0; a < 1024; a++)
            ref_mem[a] = 8'(a * 7) ^ 8'(a >> 5);

        // stores at every offset, then loads that read them back
        for (int k = 0; k < 4; k++)
            add_row(1'b1, f3_sb, 12'(k), 32'h100, 32'hC3D4E5F0 + k, 1'b0);
        add_row(1'b1, f3_sh, 12'h010, 32'h100, 32'hC3D4E5F4, 1'b0);
        add_row(1'b1, f3_sh, 12'h012, 32'h100, 32'h12348765, 1'b0);
        add_row(1'b1, f3_sw, 12'h020, 32'h100, 32'h89ABCDEF, 1'b0);
        add_row(1'b0, f3_lb, 12'h001, 32'h100, 32'h0, 1'b0);
        add_row(1'b0, f3_lbu, 12'h002, 32'h100, 32'h0, 1'b0);
        add_row(1'b0, f3_lh, 12'h012, 32'h100, 32'h0, 1'b0);
        add_row(1'b0, f3_lhu, 12'h010, 32'h100, 32'h0, 1'b0);
        add_row(1'b0, f3_lw, 12'h020, 32'h100, 32'h0, 1'b0);
        add_row(1'b0, f3_lb, 12'hFFC, 32'h147, 32'h0, 1'b0);
        add_row(1'b0, f3_lw, 12'h000, 32'h180, 32'h0, 1'b0);
        add_row(1'b1, f3_sw, 12'h024, 32'h100, 32'h5A5AA5A5, 1'b1);
        add_row(1'b0, f3_lw, 12'h024, 32'h100, 32'h0, 1'b0);

        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int i = 0; i < n_rows; i++)
            apply_row(i);

        // p20 allocated, then its load is flushed before it can write back
        dispatch(t_instr[12], 6'd5, 6'd0, 6'd20, 4'd1);
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        dispatch(t_instr[12], 6'd20, 6'd0, 6'd21, 4'd2);
        repeat (8)
        begin
            @(negedge clk);
            if ((dmem_rmask | dmem_wmask) != 4'b0000)
            begin
                $display("load issued before its base register was written");
                errors++;
            end
        end
        write_preg(6'd20, 32'h200);
        wait_request(ok);
        if (ok)
            check_value("dmem_addr", dmem_addr, (32'h200 + t_imm[12]) & 32'hFFFF_FFFC);
        wait_wb(ok);
        if (ok)
            check_preg("wb_pd", wb_pd, 6'd21);

        // blocked store at the head fills the queue, then drains in order
        @(posedge clk);
        #2;
        rob_head = 4'd0;
        dispatch(t_instr[6], 6'd5, 6'd6, 6'd0, 4'd3);
        for (int k = 0; k < 7; k++)
            dispatch(t_instr[11], 6'd5, 6'd0, PREG_W'(40 + k), ROB_W'(4 + k));
        @(negedge clk);
        check_bit("lsq_full", lsq_full, 1'b1);
        @(posedge clk);
        #2;
        rob_head = 4'd3;
        for (int k = 0; k < 8; k++)
        begin
            wait_wb(ok);
            if (ok)
                check_rob("wb_rob_index", wb_rob_index, ROB_W'(3 + k));
        end
        @(negedge clk);
        check_bit("lsq_full", lsq_full, 1'b0);

        // flush with a store in flight and loads queued behind it
        @(posedge clk);
        #2;
        rob_head = 4'd0;
        dispatch(t_instr[6], 6'd5, 6'd6, 6'd0, 4'd2);
        dispatch(t_instr[11], 6'd5, 6'd0, 6'd50, 4'd3);
        dispatch(t_instr[11], 6'd5, 6'd0, 6'd51, 4'd4);
        rob_head = 4'd2;
        @(negedge clk);
        if (dmem_wmask == 4'b0000)
        begin
            $display("store did not issue before the flush");
            errors++;
        end
        // p5 and p6 still hold the values of the last table rows
        store_ref(t_base[15] + t_imm[6], 4'b1111, t_data[14]);
        @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        for (int k = 0; k < 30; k++)
        begin
            @(negedge clk);
            if (wb_valid)
            begin
                $display("result reported after the flush");
                errors++;
            end
            if (k >= 10 && (dmem_rmask | dmem_wmask) != 4'b0000)
            begin
                $display("memory request seen after the flush without new dispatch");
                errors++;
            end
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- dv/dmem_model.sv
`timescale 1ns/100ps

module dmem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] addr,
    input  logic [3:0]  rmask,
    input  logic [3:0]  wmask,
    input  logic [31:0] wdata,
    output logic        resp,
    output logic [31:0] rdata
);

    logic [7:0] mem [1024];
    logic       waiting;
    int         cnt;

    // every byte depends on its full address
    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 7) ^ 8'(a >> 5);
    endfunction

    initial
    begin
        for (int a = 0; a < 1024; a++)
            mem[a] = fill_byte(a);
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            resp    <= 1'b0;
            waiting <= 1'b0;
            rdata   <= '0;
        end
        else if (resp)
            resp <= 1'b0;
        else if (waiting)
        begin
            if (cnt <= 1)
            begin
                resp    <= 1'b1;
                waiting <= 1'b0;
                for (int b = 0; b < 4; b++)
                begin
                    if (wmask[b])
                        mem[int'(addr[9:0]) + b] <= wdata[8*b +: 8];
                    rdata[8*b +: 8] <= mem[int'(addr[9:0]) + b];
                end
            end
            else
                cnt <= cnt - 1;
        end
        else if ((rmask | wmask) != 4'b0000)
        begin
            // 1 to 4 cycles until the response
            waiting <= 1'b1;
            cnt     <= $urandom_range(4, 1);
        end
    end

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/100ps

module lsu_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       dispatch_valid,
    input  lsu_pkg::instr_t            instr,
    input  logic [lsu_pkg::PREG_W-1:0] ps1,
    input  logic [lsu_pkg::PREG_W-1:0] ps2,
    input  logic [lsu_pkg::PREG_W-1:0] pd,
    input  logic [lsu_pkg::ROB_W-1:0]  rob_index,
    input  logic                       alu_we,
    input  logic [lsu_pkg::PREG_W-1:0] alu_pd,
    input  logic [31:0]                alu_value,
    input  logic [lsu_pkg::ROB_W-1:0]  rob_head,
    input  logic                       flush,
    output logic [31:0]                dmem_addr,
    output logic [3:0]                 dmem_rmask,
    output logic [3:0]                 dmem_wmask,
    output logic [31:0]                dmem_wdata,
    input  logic                       dmem_resp,
    input  logic [31:0]                dmem_rdata,
    output logic                       lsq_full,
    output logic                       wb_valid,
    output logic                       wb_we,
    output logic [lsu_pkg::PREG_W-1:0] wb_pd,
    output logic [31:0]                wb_value,
    output logic [lsu_pkg::ROB_W-1:0]  wb_rob_index
);

    import lsu_pkg::*;

    logic [PREG_W-1:0]    pr1_s;
    logic [PREG_W-1:0]    pr2_s;
    logic [31:0]          pr1_val;
    logic [31:0]          pr2_val;
    logic [NUM_PREGS-1:0] phys_valid;
    logic                 alloc_we;

    // a load's destination is not ready until its data returns
    assign alloc_we = dispatch_valid && (instr.i_type.opcode == op_load);

    address_unit au_i (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .instr          (instr),
        .ps1            (ps1),
        .ps2            (ps2),
        .pd             (pd),
        .rob_index      (rob_index),
        .rob_head       (rob_head),
        .phys_valid     (phys_valid),
        .pr1_s          (pr1_s),
        .pr2_s          (pr2_s),
        .pr1_val        (pr1_val),
        .pr2_val        (pr2_val),
        .lsq_full       (lsq_full),
        .dmem_addr      (dmem_addr),
        .dmem_rmask     (dmem_rmask),
        .dmem_wmask     (dmem_wmask),
        .dmem_wdata     (dmem_wdata),
        .dmem_resp      (dmem_resp),
        .dmem_rdata     (dmem_rdata),
        .wb_valid       (wb_valid),
        .wb_we          (wb_we),
        .wb_pd          (wb_pd),
        .wb_value       (wb_value),
        .wb_rob_index   (wb_rob_index)
    );

    phys_reg_file prf_i (
        .clk       (clk),
        .reset     (reset),
        .rd1_s     (pr1_s),
        .rd2_s     (pr2_s),
        .rd1_val   (pr1_val),
        .rd2_val   (pr2_val),
        .alu_we    (alu_we),
        .alu_pd    (alu_pd),
        .alu_value (alu_value),
        .ld_we     (wb_we),
        .ld_pd     (wb_pd),
        .ld_value  (wb_value),
        .alloc_we  (alloc_we),
        .alloc_pd  (pd),
        .valid_vec (phys_valid)
    );

endmodule

//--- hw/phys_reg_file.sv
`timescale 1ns/100ps

module phys_reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [lsu_pkg::PREG_W-1:0]    rd1_s,
    input  logic [lsu_pkg::PREG_W-1:0]    rd2_s,
    output logic [31:0]                   rd1_val,
    output logic [31:0]                   rd2_val,
    input  logic                          alu_we,
    input  logic [lsu_pkg::PREG_W-1:0]    alu_pd,
    input  logic [31:0]                   alu_value,
    input  logic                          ld_we,
    input  logic [lsu_pkg::PREG_W-1:0]    ld_pd,
    input  logic [31:0]                   ld_value,
    input  logic                          alloc_we,
    input  logic [lsu_pkg::PREG_W-1:0]    alloc_pd,
    output logic [lsu_pkg::NUM_PREGS-1:0] valid_vec
);

    import lsu_pkg::*;

    logic [31:0] regs [NUM_PREGS];

    always_ff @(posedge clk)
    begin
        if (alu_we && alu_pd != '0)
            regs[alu_pd] <= alu_value;
        if (ld_we && ld_pd != '0)
            regs[ld_pd] <= ld_value;
    end

    // allocation beats a write in the same cycle
    always_ff @(posedge clk)
    begin
        if (reset)
            valid_vec <= '1;
        else
        begin
            if (alu_we)
                valid_vec[alu_pd] <= 1'b1;
            if (ld_we)
                valid_vec[ld_pd] <= 1'b1;
            if (alloc_we && alloc_pd != '0)
                valid_vec[alloc_pd] <= 1'b0;
        end
    end

    assign rd1_val = (rd1_s == '0) ? 32'h0 : regs[rd1_s];
    assign rd2_val = (rd2_s == '0) ? 32'h0 : regs[rd2_s];

endmodule

//--- hw/address_unit.sv
`timescale 1ns/100ps

module address_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          dispatch_valid,
    input  lsu_pkg::instr_t               instr,
    input  logic [lsu_pkg::PREG_W-1:0]    ps1,
    input  logic [lsu_pkg::PREG_W-1:0]    ps2,
    input  logic [lsu_pkg::PREG_W-1:0]    pd,
    input  logic [lsu_pkg::ROB_W-1:0]     rob_index,
    input  logic [lsu_pkg::ROB_W-1:0]     rob_head,
    input  logic [lsu_pkg::NUM_PREGS-1:0] phys_valid,
    output logic [lsu_pkg::PREG_W-1:0]    pr1_s,
    output logic [lsu_pkg::PREG_W-1:0]    pr2_s,
    input  logic [31:0]                   pr1_val,
    input  logic [31:0]                   pr2_val,
    output logic                          lsq_full,
    output logic [31:0]                   dmem_addr,
    output logic [3:0]                    dmem_rmask,
    output logic [3:0]                    dmem_wmask,
    output logic [31:0]                   dmem_wdata,
    input  logic                          dmem_resp,
    input  logic [31:0]                   dmem_rdata,
    output logic                          wb_valid,
    output logic                          wb_we,
    output logic [lsu_pkg::PREG_W-1:0]    wb_pd,
    output logic [31:0]                   wb_value,
    output logic [lsu_pkg::ROB_W-1:0]     wb_rob_index
);

    import lsu_pkg::*;

    logic              is_store_in;
    logic              is_mem_in;
    logic [2:0]        funct3_in;
    logic [31:0]       imm_in;

    logic              issue_fire;
    logic              head_is_store;
    logic [2:0]        head_funct3;
    logic [PREG_W-1:0] head_pd;
    logic [31:0]       head_imm;
    logic [ROB_W-1:0]  head_rob_index;
    logic [31:0]       addr_sum;

    logic [3:0]        req_mask;
    logic [31:0]       req_wdata;

    // port state and the entry waiting for memory
    logic              busy;
    logic              lat_valid;
    logic              lat_is_store;
    logic [2:0]        lat_funct3;
    logic [PREG_W-1:0] lat_pd;
    logic [ROB_W-1:0]  lat_rob;
    logic [1:0]        lat_off;
    logic [31:0]       lat_addr;
    logic [3:0]        lat_rmask;
    logic [3:0]        lat_wmask;
    logic [31:0]       lat_wdata;

    // the opcode picks which view of the word holds the immediate
    always_comb
    begin
        is_store_in = (instr.s_type.opcode == op_store);
        is_mem_in   = is_store_in || (instr.i_type.opcode == op_load);
        funct3_in   = is_store_in ? instr.s_type.funct3 : instr.i_type.funct3;
        if (is_store_in)
            imm_in = {{20{instr.s_type.imm_11_5[6]}}, instr.s_type.imm_11_5,
                      instr.s_type.imm_4_0};
        else
            imm_in = {{20{instr.i_type.imm_11_0[11]}}, instr.i_type.imm_11_0};
    end

    ld_st_queue lsq_i (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .write_enable   (dispatch_valid && is_mem_in && !flush),
        .is_store       (is_store_in),
        .funct3         (funct3_in),
        .ps1            (ps1),
        .ps2            (is_store_in ? ps2 : '0),
        .pd             (is_store_in ? '0 : pd),
        .imm            (imm_in),
        .rob_index      (rob_index),
        .read_enable    (!busy && !flush),
        .rob_head       (rob_head),
        .phys_valid     (phys_valid),
        .full           (lsq_full),
        .issue_fire     (issue_fire),
        .pr1_s          (pr1_s),
        .pr2_s          (pr2_s),
        .head_is_store  (head_is_store),
        .head_funct3    (head_funct3),
        .head_pd        (head_pd),
        .head_imm       (head_imm),
        .head_rob_index (head_rob_index)
    );

    cla_adder agu_i (
        .a   (pr1_val),
        .b   (head_imm),
        .sum (addr_sum)
    );

    always_comb
    begin
        req_wdata = '0;
        case (head_funct3[1:0])
            sz_byte:
            begin
                req_mask = 4'b0001 << addr_sum[1:0];
                req_wdata[8*addr_sum[1:0] +: 8] = pr2_val[7:0];
            end
            sz_half:
            begin
                req_mask = 4'b0011 << {addr_sum[1], 1'b0};
                req_wdata[16*addr_sum[1] +: 16] = pr2_val[15:0];
            end
            default:
            begin
                req_mask  = 4'b1111;
                req_wdata = pr2_val;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            lat_valid <= 1'b0;
        end
        else if (dmem_resp)
        begin
            busy      <= 1'b0;
            lat_valid <= 1'b0;
        end
        else if (issue_fire)
        begin
            busy      <= 1'b1;
            lat_valid <= 1'b1;
        end
        else if (flush)
            lat_valid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (issue_fire)
        begin
            lat_is_store <= head_is_store;
            lat_funct3   <= head_funct3;
            lat_pd       <= head_pd;
            lat_rob      <= head_rob_index;
            lat_off      <= addr_sum[1:0];
            lat_addr     <= {addr_sum[31:2], 2'b00};
            lat_rmask    <= head_is_store ? 4'b0000 : req_mask;
            lat_wmask    <= head_is_store ? req_mask : 4'b0000;
            lat_wdata    <= head_is_store ? req_wdata : 32'h0;
        end
    end

    // request goes out in the issue cycle, then from the latches
    always_comb
    begin
        dmem_addr  = '0;
        dmem_rmask = '0;
        dmem_wmask = '0;
        dmem_wdata = '0;
        if (busy)
        begin
            dmem_addr  = lat_addr;
            dmem_rmask = lat_rmask;
            dmem_wmask = lat_wmask;
            dmem_wdata = lat_wdata;
        end
        else if (issue_fire)
        begin
            dmem_addr  = {addr_sum[31:2], 2'b00};
            dmem_rmask = head_is_store ? 4'b0000 : req_mask;
            dmem_wmask = head_is_store ? req_mask : 4'b0000;
            dmem_wdata = head_is_store ? req_wdata : 32'h0;
        end
    end

    always_comb
    begin
        case (lat_funct3)
            f3_lb:   wb_value = {{24{dmem_rdata[8*lat_off + 7]}}, dmem_rdata[8*lat_off +: 8]};
            f3_lbu:  wb_value = {24'h0, dmem_rdata[8*lat_off +: 8]};
            f3_lh:   wb_value = {{16{dmem_rdata[16*lat_off[1] + 15]}},
                                 dmem_rdata[16*lat_off[1] +: 16]};
            f3_lhu:  wb_value = {16'h0, dmem_rdata[16*lat_off[1] +: 16]};
            default: wb_value = dmem_rdata;
        endcase
    end

    // a flushed entry still takes its response but reports nothing
    assign wb_valid     = dmem_resp && busy && lat_valid;
    assign wb_we        = wb_valid && !lat_is_store;
    assign wb_pd        = lat_pd;
    assign wb_rob_index = lat_rob;

endmodule

//--- hw/ld_st_queue.sv
`timescale 1ns/100ps

module ld_st_queue (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         flush,
    input  logic                         write_enable,
    input  logic                         is_store,
    input  logic [2:0]                   funct3,
    input  logic [lsu_pkg::PREG_W-1:0]   ps1,
    input  logic [lsu_pkg::PREG_W-1:0]   ps2,
    input  logic [lsu_pkg::PREG_W-1:0]   pd,
    input  logic [31:0]                  imm,
    input  logic [lsu_pkg::ROB_W-1:0]    rob_index,
    input  logic                         read_enable,
    input  logic [lsu_pkg::ROB_W-1:0]    rob_head,
    input  logic [lsu_pkg::NUM_PREGS-1:0] phys_valid,
    output logic                         full,
    output logic                         issue_fire,
    output logic [lsu_pkg::PREG_W-1:0]   pr1_s,
    output logic [lsu_pkg::PREG_W-1:0]   pr2_s,
    output logic                         head_is_store,
    output logic [2:0]                   head_funct3,
    output logic [lsu_pkg::PREG_W-1:0]   head_pd,
    output logic [31:0]                  head_imm,
    output logic [lsu_pkg::ROB_W-1:0]    head_rob_index
);

    import lsu_pkg::*;

    logic              is_store_q [LSQ_DEPTH];
    logic [2:0]        funct3_q   [LSQ_DEPTH];
    logic [PREG_W-1:0] ps1_q      [LSQ_DEPTH];
    logic [PREG_W-1:0] ps2_q      [LSQ_DEPTH];
    logic [PREG_W-1:0] pd_q       [LSQ_DEPTH];
    logic [31:0]       imm_q      [LSQ_DEPTH];
    logic [ROB_W-1:0]  rob_q      [LSQ_DEPTH];

    logic [$clog2(LSQ_DEPTH)-1:0] head_ptr;
    logic [$clog2(LSQ_DEPTH)-1:0] tail_ptr;
    logic [$clog2(LSQ_DEPTH):0]   count;

    logic push;
    logic eligible;

    assign full = (count == LSQ_DEPTH);
    assign push = write_enable && !full;

    // payload storage
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            is_store_q[tail_ptr] <= is_store;
            funct3_q[tail_ptr]   <= funct3;
            ps1_q[tail_ptr]      <= ps1;
            ps2_q[tail_ptr]      <= ps2;
            pd_q[tail_ptr]       <= pd;
            imm_q[tail_ptr]      <= imm;
            rob_q[tail_ptr]      <= rob_index;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end
        else
        begin
            if (push)
                tail_ptr <= tail_ptr + 1'b1;
            if (issue_fire)
                head_ptr <= head_ptr + 1'b1;
            case ({push, issue_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // stores also wait for their data and for the rob head
    always_comb
    begin
        eligible = (count != '0) && phys_valid[ps1_q[head_ptr]];
        if (is_store_q[head_ptr])
            eligible = eligible && phys_valid[ps2_q[head_ptr]]
                     && (rob_q[head_ptr] == rob_head);
    end

    assign issue_fire     = read_enable && eligible;
    assign pr1_s          = ps1_q[head_ptr];
    assign pr2_s          = ps2_q[head_ptr];
    assign head_is_store  = is_store_q[head_ptr];
    assign head_funct3    = funct3_q[head_ptr];
    assign head_pd        = pd_q[head_ptr];
    assign head_imm       = imm_q[head_ptr];
    assign head_rob_index = rob_q[head_ptr];

endmodule

//--- hw/cla_adder.sv
`timescale 1ns/100ps

module cla_adder (
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] sum
);

    logic [31:0] g;
    logic [31:0] p;
    logic [31:0] c;
    // carry into each 4-bit group
    logic [8:0]  gc;

    assign g     = a & b;
    assign p     = a ^ b;
    assign gc[0] = 1'b0;

    genvar i;
    generate
        for (i = 0; i < 8; i = i + 1)
        begin : grp
            logic [3:0] gg;
            logic [3:0] pp;
            logic       cin;

            assign gg  = g[4*i +: 4];
            assign pp  = p[4*i +: 4];
            assign cin = gc[i];

            assign c[4*i]     = cin;
            assign c[4*i + 1] = gg[0] | (pp[0] & cin);
            assign c[4*i + 2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & cin);
            assign c[4*i + 3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                              | (pp[2] & pp[1] & pp[0] & cin);

            // group generate and propagate give the carry into the next group
            assign gc[i + 1] = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
                             | (pp[3] & pp[2] & pp[1] & gg[0])
                             | (pp[3] & pp[2] & pp[1] & pp[0] & cin);
        end
    endgenerate

    assign sum = p ^ c;

endmodule

//--- hw/lsu_pkg.sv
package lsu_pkg;

    localparam int NUM_PREGS = 64;
    localparam int PREG_W    = 6;
    localparam int ROB_SIZE  = 16;
    localparam int ROB_W     = 4;
    localparam int LSQ_DEPTH = 8;

    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

    // access size taken from funct3[1:0]
    localparam logic [1:0] sz_byte = 2'b00;
    localparam logic [1:0] sz_half = 2'b01;
    localparam logic [1:0] sz_word = 2'b10;

    typedef union packed {
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_type;
        struct packed {
            logic [6:0]  imm_11_5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_4_0;
            logic [6:0]  opcode;
        } s_type;
    } instr_t;

endpackage
